//--- common/nocPkg.sv
package nocPkg;

  localparam int NUM_PORTS = 5;
  localparam int SEL_W     = NUM_PORTS + 1;  // idle plus one bit per port
  localparam int KIND_W    = 3;
  localparam int LEN_W     = 12;
  localparam int DATA_W    = 16;

  // arbiter state, doubles as the grant
  typedef enum logic [SEL_W-1:0] {
    portIdle  = 6'b000001,
    portLocal = 6'b000010,
    portNorth = 6'b000100,
    portEast  = 6'b001000,
    portWest  = 6'b010000,
    portSouth = 6'b100000
  } portSel;

  typedef enum logic [KIND_W-1:0] {
    flitHeader = 3'd1,  // only kind the hardware decodes
    flitBody   = 3'd2,
    flitTail   = 3'd3
  } flitKind;

  typedef struct packed {
    flitKind             kind;
    logic [LEN_W-1:0]    length;   // valid in headers
    logic [DATA_W-1:0]   payload;
  } flitT;

  typedef struct packed {
    logic lcl;  // local port
    logic north;
    logic east;
    logic west;
    logic south;
  } portReqs;

  typedef struct packed {
    flitT lcl;
    flitT north;
    flitT east;
    flitT west;
    flitT south;
  } portFlits;

endpackage

//--- hw/arbiter/holdTimer.sv
`timescale 1ns/1ps

module holdTimer
(
  input  logic                      clk,
  input  logic                      rst,
  input  nocPkg::flitKind           kind,
  input  logic [nocPkg::LEN_W-1:0]  length,
  input  logic                      run,
  output logic                      expired
);

  logic [nocPkg::LEN_W-1:0] holdLen;  // length of the last header seen
  logic [nocPkg::LEN_W-1:0] count;    // cycles of the running grant

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      holdLen <= '0;
      count   <= '0;
    end
    else
    begin
      if (kind == nocPkg::flitHeader)
      begin
        holdLen <= length;  // latched whether granted or not
      end
      if (run)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;
      end
    end
  end

  assign expired = (count == holdLen);

endmodule

//--- hw/arbiter/outputArbiter.sv
`timescale 1ns/1ps

module outputArbiter
(
  input  logic              clk,
  input  logic              rst,
  input  nocPkg::portReqs   reqs,
  input  nocPkg::portFlits  flits,
  output nocPkg::portSel    grant
);

  // port index order matches the rotation: local, north, east, west, south
  logic [nocPkg::NUM_PORTS-1:0] reqVec;
  logic [nocPkg::NUM_PORTS-1:0] expiredVec;
  logic [nocPkg::NUM_PORTS-1:0] holdVec;   // one-hot holder, zero when idle
  logic [nocPkg::NUM_PORTS-1:0] run;
  nocPkg::flitT                 portFlit [nocPkg::NUM_PORTS];
  nocPkg::portSel               nextState;
  int                           holderIdx;

  assign reqVec = {reqs.south, reqs.west, reqs.east, reqs.north, reqs.lcl};

  assign portFlit[0] = flits.lcl;
  assign portFlit[1] = flits.north;
  assign portFlit[2] = flits.east;
  assign portFlit[3] = flits.west;
  assign portFlit[4] = flits.south;

  for (genvar i = 0; i < nocPkg::NUM_PORTS; i++)
  begin : gTimer
    holdTimer timerInst
    (
      .clk     (clk),
      .rst     (rst),
      .kind    (portFlit[i].kind),
      .length  (portFlit[i].length),
      .run     (run[i]),
      .expired (expiredVec[i])
    );
  end

  // bit 0 of the state is idle, the port bits sit above it
  assign holdVec = grant[nocPkg::SEL_W-1:1];

  // holder keeps counting while it asks and has time left
  assign run = holdVec & reqVec & ~expiredVec;

  always_comb
  begin
    holderIdx = 0;
    for (int i = 0; i < nocPkg::NUM_PORTS; i++)
    begin
      if (holdVec[i])
      begin
        holderIdx = i;
      end
    end
  end

  always_comb
  begin
    logic found;
    int   start;
    int   cand;
    nextState = nocPkg::portIdle;
    found     = 1'b0;
    start     = 0;  // from idle, local has first pick
    cand      = 0;
    if (|run)
    begin
      nextState = grant;  // hold
    end
    else
    begin
      if (|holdVec)
      begin
        start = holderIdx + 1;  // rotation starts after the holder
      end
      for (int k = 0; k < nocPkg::NUM_PORTS; k++)
      begin
        cand = start + k;
        if (cand >= nocPkg::NUM_PORTS)
        begin
          cand = cand - nocPkg::NUM_PORTS;
        end
        // released holder waits out one idle cycle before a regrant
        if (!found && reqVec[cand] && !holdVec[cand])
        begin
          nextState = nocPkg::portSel'(6'b000010 << cand);
          found     = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= nocPkg::portIdle;
    end
    else
    begin
      grant <= nextState;
    end
  end

endmodule

//--- hw/outputSwitch.sv
`timescale 1ns/1ps

module outputSwitch
(
  input  logic              clk,
  input  logic              rst,
  input  nocPkg::portSel    grant,
  input  nocPkg::portFlits  flits,
  output nocPkg::flitT      outFlit,
  output logic              outValid
);

  nocPkg::flitT selFlit;

  always_comb
  begin
    case (grant)
      nocPkg::portLocal: selFlit = flits.lcl;
      nocPkg::portNorth: selFlit = flits.north;
      nocPkg::portEast:  selFlit = flits.east;
      nocPkg::portWest:  selFlit = flits.west;
      nocPkg::portSouth: selFlit = flits.south;
      default:           selFlit = '0;  // idle drives nothing
    endcase
  end

  // output channel lags grant by one cycle
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit  <= '0;
      outValid <= 1'b0;
    end
    else
    begin
      outFlit  <= selFlit;
      outValid <= (grant != nocPkg::portIdle);
    end
  end

endmodule

//--- hw/outputPort.sv
`timescale 1ns/1ps

module outputPort
(
  input  logic              clk,
  input  logic              rst,
  input  nocPkg::portReqs   reqs,
  input  nocPkg::portFlits  flits,
  output nocPkg::portSel    grant,
  output nocPkg::flitT      outFlit,
  output logic              outValid
);

  nocPkg::portSel grantState;  // registered arbiter state

  outputArbiter arbiterInst
  (
    .clk   (clk),
    .rst   (rst),
    .reqs  (reqs),
    .flits (flits),
    .grant (grantState)
  );

  outputSwitch switchInst
  (
    .clk      (clk),
    .rst      (rst),
    .grant    (grantState),
    .flits    (flits),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  assign grant = grantState;

endmodule

//--- verification/outputPort_sva.sv
`timescale 1ns/1ps

module arbiterChecks
(
  input  logic                          clk,
  input  logic                          rst,
  input  nocPkg::portSel                grant,
  input  logic [nocPkg::NUM_PORTS-1:0]  reqVec,
  input  logic [nocPkg::NUM_PORTS-1:0]  expiredVec,
  input  logic [nocPkg::NUM_PORTS-1:0]  run
);

  logic [nocPkg::NUM_PORTS-1:0] holder;

  assign holder = grant[nocPkg::SEL_W-1:1];  // zero when idle

  legalGrant: assert property (@(posedge clk) disable iff (rst) $onehot(grant))
    else $error("grant is not a legal one-hot state");

  idleInReset: assert property (@(posedge clk) rst |=> grant == nocPkg::portIdle)
    else $error("grant did not return to idle under reset");

  // a requesting holder with time left keeps the channel
  keepHolder: assert property (@(posedge clk) disable iff (rst)
    ((holder & reqVec & ~expiredVec) != '0) |=> $stable(grant))
    else $error("grant left a port that still requested and had not expired");

  runOnlyHolder: assert property (@(posedge clk) disable iff (rst) (run & ~holder) == '0)
    else $error("hold timer running for a port that does not hold the grant");

endmodule

bind outputArbiter arbiterChecks checksInst
(
  .clk        (clk),
  .rst        (rst),
  .grant      (grant),
  .reqVec     (reqVec),
  .expiredVec (expiredVec),
  .run        (run)
);

//--- verification/outputPortTb.sv
`timescale 1ns/1ps

module outputPortTb;

  logic              clk;
  logic              rst;
  nocPkg::portReqs   reqs;
  nocPkg::portFlits  flits;
  nocPkg::portSel    grant;
  nocPkg::flitT      outFlit;
  logic              outValid;

  // scenario table, mask bit p is port p: local, north, east, west, south
  string                          rowName   [$];
  logic [4:0]                     rowReq    [$];
  logic [5*nocPkg::LEN_W-1:0]     rowLens   [$];  // local in the low bits
  int                             rowCycles [$];
  logic [4:0]                     rowDrop   [$];  // requests that fall early
  int                             rowDropAt [$];

  // reference model state
  int                             mHolder;  // -1 when idle
  logic [nocPkg::LEN_W-1:0]       mLen   [nocPkg::NUM_PORTS];
  logic [nocPkg::LEN_W-1:0]       mCount [nocPkg::NUM_PORTS];
  nocPkg::flitT                   mOutFlit;
  logic                           mOutValid;
  logic [4:0]                     curReq;
  nocPkg::flitT                   curFlit [nocPkg::NUM_PORTS];

  logic [31:0]                    rngState   = 32'he356214f;
  int                             cycleCount = 0;
  int                             cycleLimit = 100000;

  outputPort i_dut
  (
    .clk      (clk),
    .rst      (rst),
    .reqs     (reqs),
    .flits    (flits),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] nextRand();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  function automatic logic [5*nocPkg::LEN_W-1:0] lensOf(input logic [11:0] l,
    input logic [11:0] n, input logic [11:0] e, input logic [11:0] w, input logic [11:0] s);
    return {s, w, e, n, l};
  endfunction

  function automatic nocPkg::portSel codeFor(input int idx);
    case (idx)
      0:       return nocPkg::portLocal;
      1:       return nocPkg::portNorth;
      2:       return nocPkg::portEast;
      3:       return nocPkg::portWest;
      4:       return nocPkg::portSouth;
      default: return nocPkg::portIdle;
    endcase
  endfunction

  task automatic addRow(input string name, input logic [4:0] req,
    input logic [5*nocPkg::LEN_W-1:0] lens, input int cycles,
    input logic [4:0] drop, input int dropAt);
    rowName.push_back(name);
    rowReq.push_back(req);
    rowLens.push_back(lens);
    rowCycles.push_back(cycles);
    rowDrop.push_back(drop);
    rowDropAt.push_back(dropAt);
  endtask

  task automatic stopRun();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string name, input string what,
    input logic [31:0] expVal, input logic [31:0] actVal);
    $display("Mismatch %s %s expected %h actual %h", name, what, expVal, actVal);
    stopRun();
  endtask

  task automatic driveCycle(input logic [4:0] reqMask, input logic [4:0] hdrMask,
    input logic [5*nocPkg::LEN_W-1:0] lens);
    logic [31:0] rnd;
    for (int p = 0; p < nocPkg::NUM_PORTS; p++)
    begin
      rnd = nextRand();
      curFlit[p].payload = rnd[nocPkg::DATA_W-1:0];
      if (hdrMask[p])
      begin
        curFlit[p].kind   = nocPkg::flitHeader;
        curFlit[p].length = lens[p*nocPkg::LEN_W +: nocPkg::LEN_W];
      end
      else
      begin
        curFlit[p].kind   = nocPkg::flitBody;
        curFlit[p].length = '0;
      end
    end
    curReq      = reqMask;
    reqs.lcl    = reqMask[0];
    reqs.north  = reqMask[1];
    reqs.east   = reqMask[2];
    reqs.west   = reqMask[3];
    reqs.south  = reqMask[4];
    flits.lcl   = curFlit[0];
    flits.north = curFlit[1];
    flits.east  = curFlit[2];
    flits.west  = curFlit[3];
    flits.south = curFlit[4];
  endtask

  // advance the model by one clock edge using the inputs now driven
  task automatic modelStep();
    int   nextHolder;
    int   cand;
    logic holdOn;
    nextHolder = -1;
    holdOn     = 1'b0;
    if (mHolder >= 0)
    begin
      holdOn = curReq[mHolder] && (mCount[mHolder] != mLen[mHolder]);
    end
    if (holdOn)
    begin
      nextHolder = mHolder;
    end
    else
    begin
      for (int k = 1; k <= nocPkg::NUM_PORTS; k++)
      begin
        cand = (mHolder + k) % nocPkg::NUM_PORTS;  // from idle starts at local
        if (nextHolder < 0 && cand != mHolder && curReq[cand])
        begin
          nextHolder = cand;
        end
      end
    end
    mOutValid = (mHolder >= 0);
    if (mHolder >= 0)
    begin
      mOutFlit = curFlit[mHolder];
    end
    else
    begin
      mOutFlit = '0;
    end
    for (int p = 0; p < nocPkg::NUM_PORTS; p++)
    begin
      if (p == mHolder && holdOn)
      begin
        mCount[p] = mCount[p] + 12'd1;
      end
      else
      begin
        mCount[p] = '0;
      end
      if (curFlit[p].kind == nocPkg::flitHeader)
      begin
        mLen[p] = curFlit[p].length;
      end
    end
    mHolder = nextHolder;
  endtask

  task automatic checkOutputs(input string name);
    nocPkg::portSel expGrant;
    expGrant = codeFor(mHolder);
    assert (grant === expGrant)
    else reportMismatch(name, "grant", 32'(expGrant), 32'(grant));
    assert (outValid === mOutValid)
    else reportMismatch(name, "outValid", 32'(mOutValid), 32'(outValid));
    assert (outFlit === mOutFlit)
    else reportMismatch(name, "outFlit", 32'(mOutFlit), 32'(outFlit));
  endtask

  task automatic stepAndCheck(input string name);
    modelStep();
    @(posedge clk);
    #1;
    checkOutputs(name);
  endtask

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit)
    begin
      $display("Timeout: run did not complete within %0d cycles", cycleLimit);
      stopRun();
    end
  end

  initial
  begin
    logic [4:0] drop;
    addRow("idleNoReq", 5'b00000, lensOf(0, 0, 0, 0, 0), 5, 5'b00000, 0);
    addRow("singleLocalLen3", 5'b00001, lensOf(3, 0, 0, 0, 0), 12, 5'b00000, 0);
    addRow("singleNorthLen0", 5'b00010, lensOf(0, 0, 0, 0, 0), 6, 5'b00000, 0);
    addRow("allRotate", 5'b11111, lensOf(1, 2, 0, 3, 1), 18, 5'b00000, 0);
    addRow("holderDrops", 5'b11111, lensOf(8, 8, 8, 8, 8), 10, 5'b00001, 3);
    addRow("headerWhileWaiting", 5'b10001, lensOf(4, 0, 0, 0, 2), 12, 5'b00000, 0);
    cycleLimit = 10 + 20;  // reset plus margin
    for (int r = 0; r < rowName.size(); r++)
    begin
      cycleLimit = cycleLimit + rowCycles[r] + 2;
    end
    mHolder   = -1;
    mOutFlit  = '0;
    mOutValid = 1'b0;
    for (int p = 0; p < nocPkg::NUM_PORTS; p++)
    begin
      mLen[p]   = '0;
      mCount[p] = '0;
    end
    rst = 1'b1;
    driveCycle(5'b00000, 5'b00000, '0);
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int r = 0; r < rowName.size(); r++)
    begin
      for (int c = 0; c < rowCycles[r]; c++)
      begin
        drop = (c >= rowDropAt[r]) ? rowDrop[r] : 5'b00000;
        driveCycle(rowReq[r] & ~drop, (c == 0) ? rowReq[r] : 5'b00000, rowLens[r]);
        stepAndCheck(rowName[r]);
      end
      for (int c = 0; c < 2; c++)
      begin
        driveCycle(5'b00000, 5'b00000, '0);  // gap between rows
        stepAndCheck(rowName[r]);
      end
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- outputPort.f
common/nocPkg.sv
hw/arbiter/holdTimer.sv
hw/arbiter/outputArbiter.sv
hw/outputSwitch.sv
hw/outputPort.sv
verification/outputPort_sva.sv
verification/outputPortTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = outputPortTb
FILELIST  = outputPort.f
OBJDIR    = obj_dir
PASS_MSG  = Finished with no errors

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
